// File: Bender.yml
package:
  name: xr_subsys

sources:
  # package first, then leaf modules up to the top level
  - hw/xr_pkg.sv
  - hw/xr_dpram.sv
  - hw/xr_config_regs.sv
  - hw/xrmem_arb.sv
  - hw/xr_subsys_top.sv
  - target: simulation
    files:
      - sim/xr_tb.sv

// File: hw/xr_config_regs.sv
// XR configuration registers; cleared by reset, read data is combinational for the addressed register
module xr_config_regs (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    // register bus from the arbiter
    input  xr_pkg::xreg_bus_t                       xreg_i,
    output xr_pkg::word_t                           xreg_data_o,

    // all registers, towards the video side
    output xr_pkg::word_t [xr_pkg::NUM_XREGS-1:0]   cfg_o
);

    xr_pkg::word_t [xr_pkg::NUM_XREGS-1:0] regs_q;

    // register bank
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else if (xreg_i.wr) begin
            regs_q[xreg_i.addr] <= xreg_i.data;
        end
    end

    // read back the addressed register
    // the address is only XREG_AW wide, so every value hits a register
    assign xreg_data_o = regs_q[xreg_i.addr];

    // video side sees every register at once
    assign cfg_o = regs_q;

endmodule

// File: hw/xr_dpram.sv
// inferred block RAM without reset or init file; a read of the address being written returns old data
module xr_dpram #(
    parameter int AWIDTH = 8
) (
    input  logic                clk,

    // read port, data one cycle after address
    input  logic [AWIDTH-1:0]   rd_addr_i,
    output xr_pkg::word_t       rd_data_o,

    // write port
    input  logic                wr_en_i,
    input  logic [AWIDTH-1:0]   wr_addr_i,
    input  xr_pkg::word_t       wr_data_i
);

    localparam int DEPTH = 1 << AWIDTH;

    xr_pkg::word_t mem [DEPTH];

    // registered read
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // synchronous write, kept apart from the read so the RAM maps to one block
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: hw/xr_pkg.sv
// shared XR types; address bits 15:14 pick the region and widths assume 16-bit words throughout
package xr_pkg;

    // basic data word of the XR bus
    typedef logic [15:0] word_t;

    // colour lookup entry, 4 bits per channel
    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } argb_t;

    // memory index widths
    localparam int COLOR_W   = 8;
    localparam int TILE_W    = 13;
    localparam int TILE2_W   = 10;
    localparam int COPP_W    = 11;

    // configuration register bank
    localparam int NUM_XREGS = 8;
    localparam int XREG_AW   = 3;

    // region codes in address bits 15:14
    localparam logic [1:0] REGION_REGS  = 2'd0;
    localparam logic [1:0] REGION_TILE  = 2'd1;
    localparam logic [1:0] REGION_COLOR = 2'd2;
    localparam logic [1:0] REGION_COPP  = 2'd3;

    // color region view, bank picks playfield A or B
    typedef struct packed {
        logic [1:0]         region;
        logic [4:0]         unused;
        logic               bank;
        logic [COLOR_W-1:0] index;
    } color_addr_t;

    // tile region view, bank picks the 4K or the 1K tile memory
    typedef struct packed {
        logic [1:0]  region;
        logic        unused;
        logic        bank;
        logic [11:0] index;
    } tile_addr_view_t;

    // one XR address word, decoded as color or tile address
    typedef union packed {
        word_t           raw;
        color_addr_t     color;
        tile_addr_view_t tile;
    } xr_addr_u;

    // video side tile address, top bit is the bank
    typedef logic [TILE_W-1:0] tile_addr_t;

    // copper write request
    typedef struct packed {
        word_t addr;
        word_t data;
    } xr_wr_req_t;

    // write side of the configuration register bus
    typedef struct packed {
        logic               wr;
        logic [XREG_AW-1:0] addr;
        word_t              data;
    } xreg_bus_t;

endpackage

// File: hw/xr_subsys_top.sv
// XR memory subsystem top; copper engine, video timing and host bridge live outside this block
module xr_subsys_top #(
    parameter bit EN_PF_B = 1'b1,
    parameter bit EN_COPP = 1'b1
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    // XR port
    input  logic                                    xr_sel_i,
    input  logic                                    xr_wr_i,
    input  xr_pkg::word_t                           xr_addr_i,
    input  xr_pkg::word_t                           xr_data_i,
    output logic                                    xr_ack_o,
    output xr_pkg::word_t                           xr_data_o,

    // copper write port
    input  logic                                    copp_sel_i,
    input  xr_pkg::xr_wr_req_t                      copp_req_i,
    output logic                                    copp_ack_o,

    // color lookup reads
    input  logic                                    vgen_color_sel_i,
    input  logic [xr_pkg::COLOR_W-1:0]              vgen_colorA_addr_i,
    input  logic [xr_pkg::COLOR_W-1:0]              vgen_colorB_addr_i,
    output xr_pkg::argb_t                           vgen_colorA_data_o,
    output xr_pkg::argb_t                           vgen_colorB_data_o,

    // tile reads
    input  logic                                    vgen_tile_sel_i,
    input  xr_pkg::tile_addr_t                      vgen_tile_addr_i,
    output xr_pkg::word_t                           vgen_tile_data_o,

    // copper program reads
    input  logic                                    copp_prog_sel_i,
    input  logic [xr_pkg::COPP_W-1:0]               copp_prog_addr_i,
    output xr_pkg::word_t                           copp_prog_data_o,

    // configuration registers
    output xr_pkg::word_t [xr_pkg::NUM_XREGS-1:0]   cfg_o
);

    // register bus between arbiter and register bank
    xr_pkg::xreg_bus_t  xreg_bus;
    xr_pkg::word_t      xreg_data;

    xrmem_arb #(
        .EN_PF_B (EN_PF_B),
        .EN_COPP (EN_COPP)
    ) xrmem_arb0 (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .xr_sel_i           (xr_sel_i),
        .xr_wr_i            (xr_wr_i),
        .xr_addr_i          (xr_addr_i),
        .xr_data_i          (xr_data_i),
        .xr_ack_o           (xr_ack_o),
        .xr_data_o          (xr_data_o),
        .copp_sel_i         (copp_sel_i),
        .copp_req_i         (copp_req_i),
        .copp_ack_o         (copp_ack_o),
        .xreg_o             (xreg_bus),
        .xreg_data_i        (xreg_data),
        .vgen_color_sel_i   (vgen_color_sel_i),
        .vgen_colorA_addr_i (vgen_colorA_addr_i),
        .vgen_colorB_addr_i (vgen_colorB_addr_i),
        .vgen_colorA_data_o (vgen_colorA_data_o),
        .vgen_colorB_data_o (vgen_colorB_data_o),
        .vgen_tile_sel_i    (vgen_tile_sel_i),
        .vgen_tile_addr_i   (vgen_tile_addr_i),
        .vgen_tile_data_o   (vgen_tile_data_o),
        .copp_prog_sel_i    (copp_prog_sel_i),
        .copp_prog_addr_i   (copp_prog_addr_i),
        .copp_prog_data_o   (copp_prog_data_o)
    );

    xr_config_regs xr_config_regs0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .xreg_i      (xreg_bus),
        .xreg_data_o (xreg_data),
        .cfg_o       (cfg_o)
    );

endmodule

// File: hw/xrmem_arb.sv
// XR memory arbiter; copper writes beat XR, video reads beat XR reads, disabled memories read as zero
module xrmem_arb #(
    parameter bit EN_PF_B = 1'b1,
    parameter bit EN_COPP = 1'b1
) (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // XR port, read and write
    input  logic                        xr_sel_i,
    input  logic                        xr_wr_i,
    input  xr_pkg::word_t               xr_addr_i,
    input  xr_pkg::word_t               xr_data_i,
    output logic                        xr_ack_o,
    output xr_pkg::word_t               xr_data_o,

    // copper port, write only
    input  logic                        copp_sel_i,
    input  xr_pkg::xr_wr_req_t          copp_req_i,
    output logic                        copp_ack_o,

    // configuration register bus
    output xr_pkg::xreg_bus_t           xreg_o,
    input  xr_pkg::word_t               xreg_data_i,

    // color lookup reads for both playfields
    input  logic                        vgen_color_sel_i,
    input  logic [xr_pkg::COLOR_W-1:0]  vgen_colorA_addr_i,
    input  logic [xr_pkg::COLOR_W-1:0]  vgen_colorB_addr_i,
    output xr_pkg::argb_t               vgen_colorA_data_o,
    output xr_pkg::argb_t               vgen_colorB_data_o,

    // tile reads
    input  logic                        vgen_tile_sel_i,
    input  xr_pkg::tile_addr_t          vgen_tile_addr_i,
    output xr_pkg::word_t               vgen_tile_data_o,

    // copper program reads
    input  logic                        copp_prog_sel_i,
    input  logic [xr_pkg::COPP_W-1:0]   copp_prog_addr_i,
    output xr_pkg::word_t               copp_prog_data_o
);

    // decoded addresses of both ports and of the winning writer
    xr_pkg::xr_addr_u               xr_a;
    xr_pkg::xr_addr_u               copp_a;
    xr_pkg::xr_addr_u               wr_a;
    xr_pkg::word_t                  wr_data;

    // request and acknowledge control
    logic                           xr_req;
    logic                           copp_req;
    logic                           wr_go;
    logic                           copp_busy;
    logic                           xr_rd_ok;
    logic                           xr_ack_next;

    // write steering
    logic                           color_wr;
    logic                           tile_wr;

    // read addresses after the video/XR mux
    logic [xr_pkg::COLOR_W-1:0]     colorA_rd_addr;
    xr_pkg::tile_addr_t             tile_rd_addr;
    logic                           tile_bank_q;

    // memory and register read data
    xr_pkg::word_t                  xreg_rd_q;
    xr_pkg::word_t                  colorA_q;
    xr_pkg::word_t                  colorB_q;
    xr_pkg::word_t                  tile_q;
    xr_pkg::word_t                  tile2_q;
    xr_pkg::word_t                  tile_out;
    xr_pkg::word_t                  copp_q;

    assign xr_a   = xr_addr_i;
    assign copp_a = copp_req_i.addr;

    // copper is served once per select, XR only when copper is idle
    assign copp_req = copp_sel_i & ~copp_ack_o;
    assign xr_req   = xr_sel_i & ~xr_ack_o & ~copp_sel_i;

    // the copper owns the write port whenever it is served
    assign wr_a    = copp_req ? copp_a : xr_a;
    assign wr_data = copp_req ? copp_req_i.data : xr_data_i;

    // no copper memory means nothing holds off an XR read of that region
    assign copp_busy = EN_COPP & copp_prog_sel_i;

    // write enables by region, plus the register bus
    always_comb begin
        wr_go       = copp_req | (xr_req & xr_wr_i);
        color_wr    = wr_go & (wr_a.color.region == xr_pkg::REGION_COLOR);
        tile_wr     = wr_go & (wr_a.tile.region == xr_pkg::REGION_TILE);
        xreg_o.wr   = wr_go & (wr_a.color.region == xr_pkg::REGION_REGS);
        xreg_o.addr = wr_a.raw[xr_pkg::XREG_AW-1:0];
        xreg_o.data = wr_data;
    end

    // XR reads wait while video reads the same memory
    always_comb begin
        case (xr_a.color.region)
            xr_pkg::REGION_REGS:  xr_rd_ok = 1'b1;
            xr_pkg::REGION_TILE:  xr_rd_ok = ~vgen_tile_sel_i;
            xr_pkg::REGION_COLOR: xr_rd_ok = ~vgen_color_sel_i;
            default:              xr_rd_ok = ~copp_busy;
        endcase
        xr_ack_next = xr_req & (xr_wr_i | xr_rd_ok);
    end

    // read address muxes, video select wins
    assign colorA_rd_addr = vgen_color_sel_i ? vgen_colorA_addr_i : xr_a.color.index;
    assign tile_rd_addr   = vgen_tile_sel_i ? vgen_tile_addr_i
                                            : {xr_a.tile.bank, xr_a.tile.index};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xr_ack_o   <= 1'b0;
            copp_ack_o <= 1'b0;
        end else begin
            xr_ack_o   <= xr_ack_next;
            copp_ack_o <= copp_req;
        end
    end

    // tile bank of last cycle's read picks which tile RAM answers
    // register data is sampled in the request cycle so a copper write at ack time cannot disturb it
    always_ff @(posedge clk) begin
        tile_bank_q <= tile_rd_addr[xr_pkg::TILE_W-1];
        xreg_rd_q   <= xreg_data_i;
    end

    assign tile_out = tile_bank_q ? tile2_q : tile_q;

    // video outputs
    assign vgen_colorA_data_o = xr_pkg::argb_t'(colorA_q);
    assign vgen_colorB_data_o = xr_pkg::argb_t'(colorB_q);
    assign vgen_tile_data_o   = tile_out;
    assign copp_prog_data_o   = copp_q;

    // XR read data, valid in the ack cycle while the address is held
    always_comb begin
        case (xr_a.color.region)
            xr_pkg::REGION_REGS:  xr_data_o = xreg_rd_q;
            xr_pkg::REGION_TILE:  xr_data_o = tile_out;
            xr_pkg::REGION_COLOR: xr_data_o = xr_a.color.bank ? colorB_q : colorA_q;
            default:              xr_data_o = copp_q;
        endcase
    end

    // playfield A color lookup
    xr_dpram #(
        .AWIDTH (xr_pkg::COLOR_W)
    ) colormem_a (
        .clk       (clk),
        .rd_addr_i (colorA_rd_addr),
        .rd_data_o (colorA_q),
        .wr_en_i   (color_wr & ~wr_a.color.bank),
        .wr_addr_i (wr_a.color.index),
        .wr_data_i (wr_data)
    );

    // playfield B color lookup
    if (EN_PF_B) begin : g_pf_b
        logic [xr_pkg::COLOR_W-1:0] rd_addr;

        assign rd_addr = vgen_color_sel_i ? vgen_colorB_addr_i : xr_a.color.index;

        xr_dpram #(
            .AWIDTH (xr_pkg::COLOR_W)
        ) colormem_b (
            .clk       (clk),
            .rd_addr_i (rd_addr),
            .rd_data_o (colorB_q),
            .wr_en_i   (color_wr & wr_a.color.bank),
            .wr_addr_i (wr_a.color.index),
            .wr_data_i (wr_data)
        );
    end else begin : g_no_pf_b
        assign colorB_q = '0;
    end

    // main 4K tile memory
    xr_dpram #(
        .AWIDTH (xr_pkg::TILE_W - 1)
    ) tilemem (
        .clk       (clk),
        .rd_addr_i (tile_rd_addr[xr_pkg::TILE_W-2:0]),
        .rd_data_o (tile_q),
        .wr_en_i   (tile_wr & ~wr_a.tile.bank),
        .wr_addr_i (wr_a.tile.index),
        .wr_data_i (wr_data)
    );

    // second 1K tile bank, upper index bits ignored
    xr_dpram #(
        .AWIDTH (xr_pkg::TILE2_W)
    ) tilemem_2 (
        .clk       (clk),
        .rd_addr_i (tile_rd_addr[xr_pkg::TILE2_W-1:0]),
        .rd_data_o (tile2_q),
        .wr_en_i   (tile_wr & wr_a.tile.bank),
        .wr_addr_i (wr_a.tile.index[xr_pkg::TILE2_W-1:0]),
        .wr_data_i (wr_data)
    );

    // copper program memory
    if (EN_COPP) begin : g_copp
        logic [xr_pkg::COPP_W-1:0] rd_addr;
        logic                      wr_en;

        assign rd_addr = copp_prog_sel_i ? copp_prog_addr_i : xr_a.raw[xr_pkg::COPP_W-1:0];
        assign wr_en   = wr_go & (wr_a.color.region == xr_pkg::REGION_COPP);

        xr_dpram #(
            .AWIDTH (xr_pkg::COPP_W)
        ) coppermem (
            .clk       (clk),
            .rd_addr_i (rd_addr),
            .rd_data_o (copp_q),
            .wr_en_i   (wr_en),
            .wr_addr_i (wr_a.raw[xr_pkg::COPP_W-1:0]),
            .wr_data_i (wr_data)
        );
    end else begin : g_no_copp
        assign copp_q = '0;
    end

endmodule

// File: sim/xr_tb.sv
// random testbench for xr_subsys_top with both optional memories on; only indices 0..15 are used
module xr_tb;

    localparam int          PERIOD    = 20;
    localparam int          NUM_TESTS = 400;
    localparam int          NUM_FILL  = 88;
    localparam logic [31:0] SEED      = 32'hde4e3e78;

    logic                                   clk;
    logic                                   rst_n_i;
    logic                                   xr_sel_i;
    logic                                   xr_wr_i;
    xr_pkg::word_t                          xr_addr_i;
    xr_pkg::word_t                          xr_data_i;
    logic                                   xr_ack_o;
    xr_pkg::word_t                          xr_data_o;
    logic                                   copp_sel_i;
    xr_pkg::xr_wr_req_t                     copp_req_i;
    logic                                   copp_ack_o;
    logic                                   vgen_color_sel_i;
    logic [xr_pkg::COLOR_W-1:0]             vgen_colorA_addr_i;
    logic [xr_pkg::COLOR_W-1:0]             vgen_colorB_addr_i;
    xr_pkg::argb_t                          vgen_colorA_data_o;
    xr_pkg::argb_t                          vgen_colorB_data_o;
    logic                                   vgen_tile_sel_i;
    xr_pkg::tile_addr_t                     vgen_tile_addr_i;
    xr_pkg::word_t                          vgen_tile_data_o;
    logic                                   copp_prog_sel_i;
    logic [xr_pkg::COPP_W-1:0]              copp_prog_addr_i;
    xr_pkg::word_t                          copp_prog_data_o;
    xr_pkg::word_t [xr_pkg::NUM_XREGS-1:0]  cfg_o;

    // model contents keyed by memory number and index
    // 0 regs, 1 tile, 2 tile2, 3 color A, 4 color B, 5 copper
    xr_pkg::word_t mem_model [int];
    int            errors;
    int            checks;

    xr_subsys_top #(
        .EN_PF_B (1'b1),
        .EN_COPP (1'b1)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // watchdog allows 40 cycles for every request
    initial begin
        #(PERIOD * 40 * (NUM_FILL + NUM_TESTS) + PERIOD * 100);
        $display("timeout: the DUT stopped acknowledging requests");
        $display("Something failed");
        $finish;
    end

    task automatic compare(input string name, input logic [15:0] exp_v, input logic [15:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    function automatic int mem_key(input int mem, input int index);
        return mem * 65536 + index;
    endfunction

    // model key of an XR address word as decoded by region and bank
    function automatic int xr_key(input xr_pkg::word_t addr);
        case (addr[15:14])
            xr_pkg::REGION_REGS:  return mem_key(0, int'(addr[xr_pkg::XREG_AW-1:0]));
            xr_pkg::REGION_TILE:  return addr[12] ? mem_key(2, int'(addr[xr_pkg::TILE2_W-1:0]))
                                                  : mem_key(1, int'(addr[11:0]));
            xr_pkg::REGION_COLOR: return mem_key(addr[8] ? 4 : 3, int'(addr[xr_pkg::COLOR_W-1:0]));
            default:              return mem_key(5, int'(addr[xr_pkg::COPP_W-1:0]));
        endcase
    endfunction

    // random address in the small test space where ignored bits keep random junk
    function automatic xr_pkg::word_t rand_addr(input logic [1:0] region);
        xr_pkg::word_t a;
        a = xr_pkg::word_t'($urandom);
        a[15:14] = region;
        case (region)
            xr_pkg::REGION_TILE: begin
                a[9:4]   = '0;
                a[11:10] = a[12] ? a[11:10] : 2'b00;
            end
            xr_pkg::REGION_COLOR: a[7:4] = '0;
            xr_pkg::REGION_COPP:  a[10:4] = '0;
            default: ;
        endcase
        return a;
    endfunction

    // one copper and/or XR request
    // vsel holds the color, tile and copper program selects for hold cycles
    task automatic run_access(input bit use_copp, input xr_pkg::word_t caddr,
                              input xr_pkg::word_t cdata, input bit use_xr, input bit xwr,
                              input xr_pkg::word_t xaddr, input xr_pkg::word_t xdata,
                              input logic [2:0] vsel, input int hold);
        int cyc;
        int copp_cyc;
        int xr_cyc;
        int exp_lat;
        bit blocked;
        case (xaddr[15:14])
            xr_pkg::REGION_TILE:  blocked = vsel[1];
            xr_pkg::REGION_COLOR: blocked = vsel[0];
            xr_pkg::REGION_COPP:  blocked = vsel[2];
            default:              blocked = 1'b0;
        endcase
        blocked  = blocked & ~xwr;
        exp_lat  = use_copp ? 4 : (blocked ? hold + 2 : 2);
        cyc      = 0;
        copp_cyc = -1;
        xr_cyc   = -1;
        @(posedge clk);
        copp_sel_i         <= use_copp;
        copp_req_i         <= {caddr, cdata};
        xr_sel_i           <= use_xr;
        xr_wr_i            <= xwr;
        xr_addr_i          <= xaddr;
        xr_data_i          <= xdata;
        vgen_color_sel_i   <= vsel[0];
        vgen_tile_sel_i    <= vsel[1];
        copp_prog_sel_i    <= vsel[2];
        vgen_colorA_addr_i <= 8'($urandom);
        vgen_colorB_addr_i <= 8'($urandom);
        vgen_tile_addr_i   <= 13'($urandom);
        copp_prog_addr_i   <= 11'($urandom);
        while ((use_copp && copp_cyc < 0) || (use_xr && xr_cyc < 0) || cyc < hold) begin
            @(negedge clk);
            cyc++;
            if (copp_ack_o) begin
                copp_cyc = cyc;
                mem_model[xr_key(caddr)] = cdata;
            end
            if (xr_ack_o) begin
                xr_cyc = cyc;
                if (xwr) begin
                    mem_model[xr_key(xaddr)] = xdata;
                    if (xaddr[15:14] == xr_pkg::REGION_REGS)
                        compare($sformatf("cfg_o after write %h", xaddr), xdata,
                                cfg_o[xaddr[2:0]]);
                end else begin
                    compare($sformatf("xr read %h", xaddr), mem_model[xr_key(xaddr)], xr_data_o);
                end
            end
            @(posedge clk);
            if (copp_cyc == cyc)
                copp_sel_i <= 1'b0;
            if (xr_cyc == cyc)
                xr_sel_i <= 1'b0;
            if (cyc == hold) begin
                vgen_color_sel_i <= 1'b0;
                vgen_tile_sel_i  <= 1'b0;
                copp_prog_sel_i  <= 1'b0;
            end
        end
        if (use_copp)
            compare("copper ack latency", 16'd2, 16'(copp_cyc));
        if (use_xr)
            compare($sformatf("xr ack latency %h", xaddr), 16'(exp_lat), 16'(xr_cyc));
    endtask

    // all video read ports at once with data one cycle after the address
    task automatic video_read();
        logic [3:0] ia;
        logic [3:0] ib;
        logic [3:0] it;
        logic [3:0] ip;
        logic       tbank;
        ia    = 4'($urandom);
        ib    = 4'($urandom);
        it    = 4'($urandom);
        ip    = 4'($urandom);
        tbank = 1'($urandom);
        @(posedge clk);
        vgen_color_sel_i   <= 1'b1;
        vgen_tile_sel_i    <= 1'b1;
        copp_prog_sel_i    <= 1'b1;
        vgen_colorA_addr_i <= {4'd0, ia};
        vgen_colorB_addr_i <= {4'd0, ib};
        vgen_tile_addr_i   <= {tbank, 8'd0, it};
        copp_prog_addr_i   <= {7'd0, ip};
        @(posedge clk);
        vgen_color_sel_i   <= 1'b0;
        vgen_tile_sel_i    <= 1'b0;
        copp_prog_sel_i    <= 1'b0;
        @(negedge clk);
        compare("video color A", mem_model[mem_key(3, int'(ia))], vgen_colorA_data_o);
        compare("video color B", mem_model[mem_key(4, int'(ib))], vgen_colorB_data_o);
        compare("video tile", mem_model[mem_key(tbank ? 2 : 1, int'(it))], vgen_tile_data_o);
        compare("video copper", mem_model[mem_key(5, int'(ip))], copp_prog_data_o);
    endtask

    // every index of the test space gets a known value before the random mix
    task automatic fill_memories();
        for (int i = 0; i < 16; i++) begin
            for (int b = 0; b < 2; b++) begin
                run_access(1'b0, '0, '0, 1'b1, 1'b1, {2'd1, 1'b0, b[0], 8'd0, i[3:0]},
                           16'($urandom), 3'b000, 0);
                run_access(1'b0, '0, '0, 1'b1, 1'b1, {2'd2, 5'd0, b[0], 4'd0, i[3:0]},
                           16'($urandom), 3'b000, 0);
            end
            run_access(1'b0, '0, '0, 1'b1, 1'b1, {2'd3, 10'd0, i[3:0]},
                       16'($urandom), 3'b000, 0);
            if (i < 8)
                run_access(1'b0, '0, '0, 1'b1, 1'b1, {13'd0, i[2:0]}, 16'($urandom), 3'b000, 0);
        end
    endtask

    initial begin
        int            kind;
        bit            xwr;
        xr_pkg::word_t xaddr;
        xr_pkg::word_t caddr;
        void'($urandom(SEED));
        errors             = 0;
        checks             = 0;
        rst_n_i            = 1'b0;
        // an XR read and a copper write to register 0 stay pending through reset
        xr_sel_i           = 1'b1;
        xr_wr_i            = 1'b0;
        xr_addr_i          = '0;
        xr_data_i          = '0;
        copp_sel_i         = 1'b1;
        copp_req_i         = {16'h0000, 16'hffff};
        vgen_color_sel_i   = 1'b0;
        vgen_colorA_addr_i = '0;
        vgen_colorB_addr_i = '0;
        vgen_tile_sel_i    = 1'b0;
        vgen_tile_addr_i   = '0;
        copp_prog_sel_i    = 1'b0;
        copp_prog_addr_i   = '0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare("xr_ack_o in reset", '0, 16'(xr_ack_o));
        compare("copp_ack_o in reset", '0, 16'(copp_ack_o));
        @(posedge clk);
        rst_n_i    <= 1'b1;
        xr_sel_i   <= 1'b0;
        copp_sel_i <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < xr_pkg::NUM_XREGS; i++)
            compare($sformatf("cfg_o[%0d] after reset", i), '0, cfg_o[i]);

        fill_memories();
        for (int n = 0; n < NUM_TESTS; n++) begin
            kind  = int'($urandom % 8);
            xwr   = 1'($urandom);
            xaddr = rand_addr(2'($urandom));
            caddr = rand_addr(2'($urandom));
            case (kind)
                0, 1, 2, 3: run_access(1'b0, caddr, '0, 1'b1, xwr, xaddr, 16'($urandom),
                                       3'b000, 0);
                4: run_access(1'b1, caddr, 16'($urandom), 1'b0, 1'b0, xaddr, '0, 3'b000, 0);
                // half of the races hit the address the copper just wrote
                5: run_access(1'b1, caddr, 16'($urandom), 1'b1, xwr, n[0] ? caddr : xaddr,
                              16'($urandom), 3'b000, 0);
                6: video_read();
                default: run_access(1'b0, caddr, '0, 1'b1, xwr, xaddr, 16'($urandom),
                                    3'($urandom), int'($urandom % 4) + 1);
            endcase
        end

        @(negedge clk);
        for (int i = 0; i < xr_pkg::NUM_XREGS; i++)
            compare($sformatf("cfg_o[%0d] at end", i), mem_model[mem_key(0, i)], cfg_o[i]);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/xr_pkg.sv
hw/xr_dpram.sv
hw/xr_config_regs.sv
hw/xrmem_arb.sv
hw/xr_subsys_top.sv
sim/xr_tb.sv
